// File: verilog/sct_out_pkg.sv
`default_nettype none

package sct_out_pkg;

  // Default queue sizing.
  // The top level passes these down, and the depth must be a power of two.
  localparam int queue_depth_dflt = 8;
  localparam int count_width_dflt = 4;

  // Shape of a read return burst from the cache bank.
  // A read header is always followed by this many data words.
  localparam int burst_words = 16;

  // Number of 32-bit words packed into one 128-bit queue entry.
  localparam int words_per_entry = 4;

  // Destination code that selects this return path.
  // Headers with any other code belong to another unit and are ignored.
  localparam logic [1:0] dest_return = 2'd1;

  // Header word layout with the most significant field first.
  typedef struct packed {
    // Set for a read return, clear for a write acknowledgement.
    logic        read;
    logic [12:0] rsvd_hi;
    // Return path select.
    logic [1:0]  dest;
    // Set for a 16-byte read, clear for a 64-byte read.
    logic        subline;
    logic        install_state;
    logic        unmapped_err;
    // Job id of the originating bus request.
    logic [5:0]  jid;
    logic [6:0]  rsvd_lo;
  } sct_header_t;

  // One input word.
  // It is read as a header in the header cycle and as payload otherwise.
  typedef union packed {
    logic [31:0] data;
    sct_header_t hdr;
  } sct_word_t;

  // Attributes carried next to each 128-bit queue entry.
  typedef struct packed {
    // Also tells the drain how many beats the transaction has.
    logic       subline;
    logic       install_state;
    logic       unmapped_err;
    logic [5:0] jid;
    // OR of the uncorrectable-error flags of the four packed words.
    logic       ue;
  } sct_attr_t;

  // Decoded transaction type of a header.
  typedef enum logic [1:0] {
    trans_none = 2'd0,
    trans_wr   = 2'd1,
    trans_rd16 = 2'd2,
    trans_rd64 = 2'd3
  } sct_trans_t;

endpackage

`default_nettype wire

// File: verilog/sct_return_router.sv
`default_nettype none

module sct_return_router (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire sct_out_pkg::sct_word_t word_in,
  input  wire                         header_valid,
  input  wire                         ue_err,
  output logic                        wr_ack,
  output logic                        enq,
  output logic [127:0]                enq_data,
  output sct_out_pkg::sct_attr_t      enq_attr,
  output logic                        trans_done
);

  // Word counter over the data burst.
  localparam int cnt_w = $clog2(sct_out_pkg::burst_words);
  // Position of a word inside its group of four.
  localparam int grp_w = $clog2(sct_out_pkg::words_per_entry);
  // The last word of a group goes straight from the stage register.
  localparam int pack_w = 32 * (sct_out_pkg::words_per_entry - 1);

  // Burst FSM encoding.
  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_rd16 = 2'd1;
  localparam logic [1:0] st_rd64 = 2'd2;

  sct_out_pkg::sct_word_t  word_p1;
  logic                    hdr_vld_p1;
  logic                    ue_p1;
  sct_out_pkg::sct_trans_t trans;
  logic [1:0]              state;
  logic [1:0]              next_state;
  logic                    save_hdr;
  logic                    in_burst;
  logic [cnt_w-1:0]        cnt;
  logic [grp_w-1:0]        grp_pos;
  logic                    burst_last;
  logic                    grp_last;
  logic                    rd16_last;
  logic                    ue_acc;
  logic                    ue_cur;
  logic [pack_w-1:0]       pack;
  logic                    saved_subline;
  logic                    saved_install;
  logic                    saved_unmapped;
  logic [5:0]              saved_jid;

  // Input stage.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hdr_vld_p1 <= 1'b0;
    end else begin
      hdr_vld_p1 <= header_valid;
    end
  end

  always_ff @(posedge clk) begin
    word_p1 <= word_in;
    ue_p1   <= ue_err;
  end

  // Header decode on the staged word.
  // The destination filter comes first.
  // Read flag and subline then pick the type.
  always_comb begin
    trans = sct_out_pkg::trans_none;
    if (hdr_vld_p1 && (word_p1.hdr.dest == sct_out_pkg::dest_return)) begin
      if (!word_p1.hdr.read) begin
        trans = sct_out_pkg::trans_wr;
      end else if (word_p1.hdr.subline) begin
        trans = sct_out_pkg::trans_rd16;
      end else begin
        trans = sct_out_pkg::trans_rd64;
      end
    end
  end

  assign in_burst   = (state == st_rd16) || (state == st_rd64);
  assign grp_pos    = cnt[grp_w-1:0];
  assign burst_last = (cnt == cnt_w'(sct_out_pkg::burst_words - 1));
  assign grp_last   = (grp_pos == grp_w'(sct_out_pkg::words_per_entry - 1));
  // A 16-byte read keeps only group 0.
  assign rd16_last  = (cnt == cnt_w'(sct_out_pkg::words_per_entry - 1));

  // Burst FSM.
  // Headers are only honoured in idle.
  // The source never overlaps bursts.
  always_comb begin
    next_state = state;
    save_hdr   = 1'b0;
    case (state)
      st_idle: begin
        if (trans == sct_out_pkg::trans_rd16) begin
          next_state = st_rd16;
          save_hdr   = 1'b1;
        end else if (trans == sct_out_pkg::trans_rd64) begin
          next_state = st_rd64;
          save_hdr   = 1'b1;
        end
      end
      st_rd16, st_rd64: begin
        // Both reads walk all 16 words.
        // A short read just drops the tail.
        if (burst_last) begin
          next_state = st_idle;
        end
      end
      // Unused encoding that is never entered.
      default: next_state = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= st_idle;
      cnt    <= '0;
      wr_ack <= 1'b0;
      ue_acc <= 1'b0;
    end else begin
      state  <= next_state;
      // Wraps to zero after the last word.
      cnt    <= in_burst ? cnt + 1'b1 : '0;
      wr_ack <= (state == st_idle) && (trans == sct_out_pkg::trans_wr);
      ue_acc <= ue_cur;
    end
  end

  // Running error flag that restarts on the first word of each group.
  assign ue_cur = (grp_pos == '0) ? ue_p1 : (ue_p1 | ue_acc);

  // Collect the first three words of a group with the lowest word at bit 0.
  always_ff @(posedge clk) begin
    if (in_burst && !grp_last) begin
      pack[grp_pos*32 +: 32] <= word_p1.data;
    end
  end

  // Attributes captured from the header.
  always_ff @(posedge clk) begin
    if (save_hdr) begin
      saved_subline  <= word_p1.hdr.subline;
      saved_install  <= word_p1.hdr.install_state;
      saved_unmapped <= word_p1.hdr.unmapped_err;
      saved_jid      <= word_p1.hdr.jid;
    end
  end

  // Enqueue while the fourth word of a group sits in the stage register.
  assign enq        = ((state == st_rd64) && grp_last) || ((state == st_rd16) && rd16_last);
  assign trans_done = ((state == st_rd64) && burst_last) || ((state == st_rd16) && rd16_last);
  assign enq_data   = {word_p1.data, pack};

  always_comb begin
    enq_attr.subline       = saved_subline;
    enq_attr.install_state = saved_install;
    enq_attr.unmapped_err  = saved_unmapped;
    enq_attr.jid           = saved_jid;
    enq_attr.ue            = ue_cur;
  end

endmodule

`default_nettype wire

// File: verilog/sct_return_queue.sv
`default_nettype none

module sct_return_queue #(
  parameter int QUEUE_DEPTH = sct_out_pkg::queue_depth_dflt,
  parameter int COUNT_WIDTH = sct_out_pkg::count_width_dflt
) (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire                         enq,
  input  wire [127:0]                 enq_data,
  input  wire sct_out_pkg::sct_attr_t enq_attr,
  input  wire                         trans_done,
  input  wire                         deq,
  input  wire                         dec_count,
  output logic [127:0]                deq_data,
  output sct_out_pkg::sct_attr_t      deq_attr,
  output logic                        empty,
  output logic [COUNT_WIDTH-1:0]      trans_count,
  output logic                        credit_return
);

  // The pointers wrap on their own with a power-of-two depth.
  localparam int ptr_w = $clog2(QUEUE_DEPTH);

  logic [127:0]           data_mem [QUEUE_DEPTH];
  sct_out_pkg::sct_attr_t attr_mem [QUEUE_DEPTH];
  logic [ptr_w-1:0]       wr_ptr;
  logic [ptr_w-1:0]       rd_ptr;
  // One extra bit so a full queue is distinct from an empty one.
  logic [ptr_w:0]         occ;

  // Entry store.
  // Credits toward the source keep every write within the free entries.
  always_ff @(posedge clk) begin
    if (enq) begin
      data_mem[wr_ptr] <= enq_data;
      attr_mem[wr_ptr] <= enq_attr;
    end
  end

  // Pointer update.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (enq) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (deq) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Occupancy count.
  // Push and pop in the same cycle leave it unchanged.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      occ <= '0;
    end else begin
      case ({enq, deq})
        2'b10:   occ <= occ + 1'b1;
        2'b01:   occ <= occ - 1'b1;
        default: occ <= occ;
      endcase
    end
  end

  assign empty = (occ == '0);

  // Head entry is always visible to the drain.
  assign deq_data = data_mem[rd_ptr];
  assign deq_attr = attr_mem[rd_ptr];

  // Complete transactions held in the queue.
  // Counts up when the router writes a final entry.
  // Counts down when the drain sends a final beat.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      trans_count <= '0;
    end else begin
      case ({trans_done, dec_count})
        2'b10:   trans_count <= trans_count + 1'b1;
        2'b01:   trans_count <= trans_count - 1'b1;
        default: trans_count <= trans_count;
      endcase
    end
  end

  // One credit back to the source for every entry freed.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credit_return <= 1'b0;
    end else begin
      credit_return <= deq;
    end
  end

endmodule

`default_nettype wire

// File: verilog/jbus_return_drain.sv
`default_nettype none

module jbus_return_drain #(
  parameter int COUNT_WIDTH = sct_out_pkg::count_width_dflt
) (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire [127:0]                 deq_data,
  input  wire sct_out_pkg::sct_attr_t deq_attr,
  input  wire                         empty,
  input  wire [COUNT_WIDTH-1:0]       trans_count,
  output logic                        deq,
  output logic                        dec_count,
  output logic [127:0]                out_data,
  output sct_out_pkg::sct_attr_t      out_attr,
  output logic                        out_last,
  output logic                        out_valid,
  input  wire                         out_ready
);

  // Beats in a 64-byte read.
  localparam int beats_rd64 = sct_out_pkg::burst_words / sct_out_pkg::words_per_entry;
  localparam int beat_w     = $clog2(beats_rd64);

  logic              xfer;
  logic              load_ok;
  logic              pend_last;
  logic              start_ok;
  logic              active;
  logic [beat_w-1:0] beat;
  logic              last_next;

  assign xfer      = out_valid && out_ready;
  // Output register is free or empties this cycle.
  assign load_ok   = !out_valid || xfer;
  // A final beat still waiting is still in trans_count.
  assign pend_last = out_valid && out_last;
  // Only start a transaction that is fully in the queue.
  assign start_ok  = pend_last ? (trans_count > COUNT_WIDTH'(1)) : (trans_count != '0);

  // Pop the head into the output register.
  assign deq = load_ok && !empty && (active || start_ok);

  // Beat total comes from subline on the first entry.
  assign last_next = active ? (beat == beat_w'(beats_rd64 - 1)) : deq_attr.subline;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      out_last  <= 1'b0;
      active    <= 1'b0;
      beat      <= '0;
    end else begin
      if (deq) begin
        out_valid <= 1'b1;
        out_last  <= last_next;
        active    <= !last_next;
        beat      <= last_next ? '0 : beat + 1'b1;
      end else if (xfer) begin
        out_valid <= 1'b0;
        out_last  <= 1'b0;
      end
    end
  end

  // Beat payload is held until it transfers.
  always_ff @(posedge clk) begin
    if (deq) begin
      out_data <= deq_data;
      out_attr <= deq_attr;
    end
  end

  // Transaction leaves the queue with its final beat.
  assign dec_count = xfer && out_last;

endmodule

`default_nettype wire

// File: verilog/sct_out_queues.sv
`default_nettype none

module sct_out_queues #(
  parameter int QUEUE_DEPTH = sct_out_pkg::queue_depth_dflt,
  parameter int COUNT_WIDTH = sct_out_pkg::count_width_dflt
) (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire sct_out_pkg::sct_word_t word_in,
  input  wire                         header_valid,
  input  wire                         ue_err,
  output wire                         wr_ack,
  output wire                         credit_return,
  output wire [127:0]                 out_data,
  output wire sct_out_pkg::sct_attr_t out_attr,
  output wire                         out_last,
  output wire                         out_valid,
  input  wire                         out_ready,
  output wire [COUNT_WIDTH-1:0]       trans_count
);

  // Router to queue.
  wire                         enq;
  wire [127:0]                 enq_data;
  wire sct_out_pkg::sct_attr_t enq_attr;
  wire                         trans_done;

  // Queue and drain handshake.
  wire [127:0]                 deq_data;
  wire sct_out_pkg::sct_attr_t deq_attr;
  wire                         empty;
  wire                         deq;
  wire                         dec_count;

  // Header decode, burst FSM and 4:1 packing.
  sct_return_router sct_return_router_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .word_in      (word_in),
    .header_valid (header_valid),
    .ue_err       (ue_err),
    .wr_ack       (wr_ack),
    .enq          (enq),
    .enq_data     (enq_data),
    .enq_attr     (enq_attr),
    .trans_done   (trans_done)
  );

  // Entry buffer with transaction count and credit return.
  sct_return_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .COUNT_WIDTH (COUNT_WIDTH)
  ) sct_return_queue_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .enq           (enq),
    .enq_data      (enq_data),
    .enq_attr      (enq_attr),
    .trans_done    (trans_done),
    .deq           (deq),
    .dec_count     (dec_count),
    .deq_data      (deq_data),
    .deq_attr      (deq_attr),
    .empty         (empty),
    .trans_count   (trans_count),
    .credit_return (credit_return)
  );

  // Bus-side valid/ready output.
  jbus_return_drain #(
    .COUNT_WIDTH (COUNT_WIDTH)
  ) jbus_return_drain_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .deq_data    (deq_data),
    .deq_attr    (deq_attr),
    .empty       (empty),
    .trans_count (trans_count),
    .deq         (deq),
    .dec_count   (dec_count),
    .out_data    (out_data),
    .out_attr    (out_attr),
    .out_last    (out_last),
    .out_valid   (out_valid),
    .out_ready   (out_ready)
  );

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD = 100
) (
  output logic clk
);

  // Starts low, so the first rising edge is half a period in.
  initial clk = 1'b0;

  always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

// File: testbench/tb_sct_out_queues.sv
`default_nettype none

module tb_sct_out_queues;

  localparam int QUEUE_DEPTH = 8;
  localparam int COUNT_WIDTH = 4;
  localparam int clk_period  = 100;

  // Cycle budget of each test.
  localparam int len_reset_wr = 40;
  localparam int len_rd16     = 100;
  localparam int len_rd64     = 100;
  localparam int len_backpr   = 500;
  localparam int len_credits  = 200;
  localparam int watchdog_cycles =
    2 * (len_reset_wr + len_rd16 + len_rd64 + len_backpr + len_credits) + 200;
  // Longest wait for the DUT to go idle between tests.
  localparam int idle_limit = 200;

  // out_ready modes.
  localparam int ready_high   = 0;
  localparam int ready_random = 1;
  localparam int ready_low    = 2;

  logic                   clk;
  logic                   rst_n;
  sct_out_pkg::sct_word_t word_in;
  logic                   header_valid;
  logic                   ue_err;
  logic                   out_ready;
  wire                    wr_ack;
  wire                    credit_return;
  wire [127:0]            out_data;
  wire sct_out_pkg::sct_attr_t out_attr;
  wire                    out_last;
  wire                    out_valid;
  wire [COUNT_WIDTH-1:0]  trans_count;

  integer seed;
  int     errors;
  int     tests_run;
  int     tests_failed;
  int     test_err_start;
  string  test_name;
  int     ready_mode;
  // Source-side credit counter.
  int     credits;
  // Rising edges seen since time zero.
  int     cyc;
  // Model of trans_count after the latest edge.
  int     exp_tc;

  // Reference model, filled by the stimulus.
  logic [127:0]           exp_data_q [$];
  sct_out_pkg::sct_attr_t exp_attr_q [$];
  logic                   exp_last_q [$];
  int                     ack_edges [$];
  int                     done_edges [$];

  logic                   exp_ack;
  logic [127:0]           exp_d;
  sct_out_pkg::sct_attr_t exp_a;
  logic                   exp_l;

  tb_clock_gen #(.PERIOD(clk_period)) tb_clock_gen_inst (.clk(clk));

  sct_out_queues #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .COUNT_WIDTH (COUNT_WIDTH)
  ) sct_out_queues_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .word_in       (word_in),
    .header_valid  (header_valid),
    .ue_err        (ue_err),
    .wr_ack        (wr_ack),
    .credit_return (credit_return),
    .out_data      (out_data),
    .out_attr      (out_attr),
    .out_last      (out_last),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .trans_count   (trans_count)
  );

  task automatic flag_mismatch(input string what, input logic [127:0] exp, input logic [127:0] act);
    $display("CHECK FAILED %s: %s expected %h actual %h", test_name, what, exp, act);
    errors = errors + 1;
  endtask

  task automatic note_problem(input string msg);
    $display("Problem in test %s: %s", test_name, msg);
    errors = errors + 1;
  endtask

  // Waits one falling edge, returns inputs to idle and sets out_ready per mode.
  task automatic next_cycle();
    @(negedge clk);
    header_valid = 1'b0;
    ue_err       = 1'b0;
    case (ready_mode)
      ready_random: out_ready = ($random(seed) % 3) != 0;
      ready_low:    out_ready = 1'b0;
      default:      out_ready = 1'b1;
    endcase
  endtask

  // Ack is due two edges after the header edge.
  task automatic write_header(input logic [1:0] dest, input logic [5:0] jid);
    sct_out_pkg::sct_header_t hdr;
    hdr      = '0;
    hdr.read = 1'b0;
    hdr.dest = dest;
    hdr.jid  = jid;
    next_cycle();
    header_valid = 1'b1;
    word_in.hdr  = hdr;
    if (dest == sct_out_pkg::dest_return) begin
      ack_edges.push_back(cyc + 3);
    end
  endtask

  // Sends a header and 16 random words.
  // Expected beats go in as each group completes.
  task automatic read_burst(input logic rd16, input logic [1:0] dest, input logic [5:0] jid,
                            input logic install, input logic unmapped, input logic [15:0] ue_mask);
    sct_out_pkg::sct_header_t hdr;
    sct_out_pkg::sct_attr_t   attr;
    logic [31:0]              words [16];
    logic                     accepted;
    int                       need;
    int                       i;
    int                       g;
    need     = rd16 ? 1 : 4;
    accepted = (dest == sct_out_pkg::dest_return);
    if (accepted) begin
      while (credits < need) begin
        next_cycle();
      end
      credits = credits - need;
    end
    hdr               = '0;
    hdr.read          = 1'b1;
    hdr.rsvd_hi       = 13'($random(seed));
    hdr.dest          = dest;
    hdr.subline       = rd16;
    hdr.install_state = install;
    hdr.unmapped_err  = unmapped;
    hdr.jid           = jid;
    next_cycle();
    header_valid = 1'b1;
    word_in.hdr  = hdr;
    // Final entry lands 5 or 17 edges after the header edge.
    if (accepted) begin
      done_edges.push_back(cyc + 1 + (rd16 ? 5 : 17));
    end
    for (i = 0; i < 16; i++) begin
      next_cycle();
      words[i]     = $random(seed);
      word_in.data = words[i];
      ue_err       = ue_mask[i];
      if (accepted && (i % 4 == 3) && (!rd16 || i == 3)) begin
        g                  = i / 4;
        attr.subline       = rd16;
        attr.install_state = install;
        attr.unmapped_err  = unmapped;
        attr.jid           = jid;
        attr.ue            = |ue_mask[4*g +: 4];
        exp_data_q.push_back({words[i], words[i-1], words[i-2], words[i-3]});
        exp_attr_q.push_back(attr);
        exp_last_q.push_back(rd16 || (g == 3));
      end
    end
  endtask

  // Runs until every expected beat, ack and credit is back.
  task automatic drain_all();
    int n;
    n = 0;
    while ((exp_data_q.size() != 0 || done_edges.size() != 0 || ack_edges.size() != 0 ||
            out_valid || credits != QUEUE_DEPTH) && n < idle_limit) begin
      next_cycle();
      n = n + 1;
    end
    assert (exp_data_q.size() == 0) else note_problem("expected beats never left the DUT");
    assert (!out_valid) else note_problem("a beat is still waiting on the output");
    assert (credits == QUEUE_DEPTH) else flag_mismatch("credits", QUEUE_DEPTH, credits);
    assert (trans_count == '0) else flag_mismatch("trans_count", 0, trans_count);
  endtask

  task automatic begin_test(input string name);
    test_name      = name;
    test_err_start = errors;
  endtask

  task automatic close_test();
    int n_err;
    n_err     = errors - test_err_start;
    tests_run = tests_run + 1;
    if (n_err == 0) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed = tests_failed + 1;
      $display("test %s: %0d check(s) failed", test_name, n_err);
    end
  endtask

  // Monitor.
  // Reads the values from just before each rising edge.
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (rst_n) begin
      exp_ack = (ack_edges.size() != 0) && (ack_edges[0] == cyc);
      if (exp_ack) begin
        void'(ack_edges.pop_front());
      end
      assert (wr_ack == exp_ack) else flag_mismatch("wr_ack", exp_ack, wr_ack);
      assert (int'(trans_count) == exp_tc) else flag_mismatch("trans_count", exp_tc, trans_count);
      // Count this edge's final-entry write.
      if ((done_edges.size() != 0) && (done_edges[0] == cyc)) begin
        void'(done_edges.pop_front());
        exp_tc = exp_tc + 1;
      end
      if (credit_return) begin
        credits = credits + 1;
      end
      assert (credits <= QUEUE_DEPTH) else note_problem("more credits came back than were spent");
      if (out_valid && out_ready) begin
        assert (exp_data_q.size() != 0) else note_problem("a beat came out with none expected");
        if (exp_data_q.size() != 0) begin
          exp_d = exp_data_q.pop_front();
          exp_a = exp_attr_q.pop_front();
          exp_l = exp_last_q.pop_front();
          assert (out_data == exp_d) else flag_mismatch("out_data", exp_d, out_data);
          assert (out_attr == exp_a) else flag_mismatch("out_attr", exp_a, out_attr);
          assert (out_last == exp_l) else flag_mismatch("out_last", exp_l, out_last);
          // A final beat retires its transaction.
          if (exp_l) begin
            exp_tc = exp_tc - 1;
          end
        end
      end
    end
  end

  // A stalled beat holds still.
  assert property (@(posedge clk) disable iff (!rst_n)
      (out_valid && !out_ready) |=>
      (out_valid && $stable(out_data) && $stable(out_attr) && $stable(out_last)))
    else note_problem("a beat changed or vanished while out_ready was low");

  assert property (@(posedge clk) disable iff (!rst_n) out_last |-> out_valid)
    else note_problem("out_last was high without out_valid");

  // Watchdog.
  initial begin
    #(watchdog_cycles * clk_period);
    $display("Watchdog expired, the run did not finish in time");
    $display("Testbench failed");
    $finish;
  end

  initial begin
    int          n;
    int          kind;
    logic [15:0] mask;
    logic [5:0]  jid;
    seed         = 32'he526;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    cyc          = 0;
    exp_tc       = 0;
    credits      = QUEUE_DEPTH;
    ready_mode   = ready_high;
    rst_n        = 1'b0;
    word_in      = '0;
    header_valid = 1'b0;
    ue_err       = 1'b0;
    out_ready    = 1'b1;

    // Reset, then writes only.
    begin_test("reset_and_writes");
    repeat (4) next_cycle();
    rst_n = 1'b1;
    assert ({wr_ack, credit_return, out_valid, out_last} == 4'b0)
      else flag_mismatch("outputs after reset", 0, {wr_ack, credit_return, out_valid, out_last});
    assert (trans_count == '0) else flag_mismatch("trans_count after reset", 0, trans_count);
    write_header(sct_out_pkg::dest_return, 6'h01);
    write_header(sct_out_pkg::dest_return, 6'h02);
    repeat (3) next_cycle();
    write_header(sct_out_pkg::dest_return, 6'h3f);
    drain_all();
    close_test();

    // Short reads, plus headers for another unit.
    begin_test("read_16_byte");
    read_burst(1'b1, sct_out_pkg::dest_return, 6'h15, 1'b1, 1'b0, 16'h0004);
    // Error on a dropped word must not show.
    read_burst(1'b1, sct_out_pkg::dest_return, 6'h2a, 1'b0, 1'b1, 16'h0010);
    read_burst(1'b1, 2'd2, 6'h07, 1'b0, 1'b0, 16'h0000);
    write_header(2'd0, 6'h08);
    drain_all();
    close_test();

    begin_test("read_64_byte");
    // Group 1 error sets ue on beat 2 only.
    read_burst(1'b0, sct_out_pkg::dest_return, 6'h33, 1'b0, 1'b0, 16'h0020);
    read_burst(1'b0, sct_out_pkg::dest_return, 6'h0c, 1'b1, 1'b1, 16'h8001);
    drain_all();
    close_test();

    // Random mix against a random out_ready.
    begin_test("back_pressure");
    ready_mode = ready_random;
    for (n = 0; n < 10; n++) begin
      kind = {$random(seed)} % 3;
      jid  = 6'($random(seed));
      mask = 16'($random(seed) & $random(seed));
      case (kind)
        0:       write_header(sct_out_pkg::dest_return, jid);
        1:       read_burst(1'b1, sct_out_pkg::dest_return, jid, mask[0], mask[1], mask);
        default: read_burst(1'b0, sct_out_pkg::dest_return, jid, mask[1], mask[0], mask);
      endcase
    end
    drain_all();
    ready_mode = ready_high;
    close_test();

    // Fill every entry with the bus stalled, then drain.
    begin_test("credits");
    ready_mode = ready_low;
    read_burst(1'b0, sct_out_pkg::dest_return, 6'h11, 1'b0, 1'b0, 16'h0100);
    read_burst(1'b0, sct_out_pkg::dest_return, 6'h12, 1'b1, 1'b0, 16'h0000);
    read_burst(1'b1, sct_out_pkg::dest_return, 6'h13, 1'b0, 1'b1, 16'h0001);
    repeat (8) next_cycle();
    assert (int'(trans_count) == 3) else flag_mismatch("trans_count when full", 3, trans_count);
    assert (out_valid) else note_problem("no beat was offered while the queue was full");
    ready_mode = ready_high;
    drain_all();
    close_test();

    $display("tests run %0d, tests failed %0d, checks failed %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sct_out_queues.f
verilog/sct_out_pkg.sv
verilog/sct_return_router.sv
verilog/sct_return_queue.sv
verilog/jbus_return_drain.sv
verilog/sct_out_queues.sv
testbench/tb_clock_gen.sv
testbench/tb_sct_out_queues.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_sct_out_queues \
  -f sct_out_queues.f \
  --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -qx "Testbench passed" sim.log; then
  echo "RESULT: PASS"
  exit 0
else
  echo "RESULT: FAIL"
  exit 1
fi
